//--- rtl/husky_pkg.sv
package husky_pkg;

   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;
   typedef logic [4:0] trig_src_t;   // io1, io2, io3, io4, nrst from bit 0

   typedef struct packed {
      reg_addr_t addr;
      reg_data_t wdata;
      logic      rd;                 // One-cycle read strobe
      logic      wr;                 // One-cycle write strobe
   } reg_bus_t;

   typedef struct packed {
      logic val;
      logic oe;
   } pin_drive_t;

   typedef struct packed {
      pin_drive_t nrst;
      pin_drive_t pdid;
      pin_drive_t pdic;
      pin_drive_t mosi;
      pin_drive_t sck;
      pin_drive_t sam_miso;
   } target_pins_t;

   typedef enum logic [1:0] {
      BUS_IDLE  = 2'd0,
      BUS_WRITE = 2'd1,
      BUS_READ  = 2'd2
   } bus_state_e;

   // Register map
   localparam reg_addr_t ADDR_ID          = 8'h00;
   localparam reg_addr_t ADDR_STATUS      = 8'h01;
   localparam reg_addr_t ADDR_TARGET_CTRL = 8'h02;
   localparam reg_addr_t ADDR_TRIG_SRC    = 8'h03;
   localparam reg_addr_t ADDR_TRIG_MODE   = 8'h04;

   localparam reg_data_t BOARD_ID = 8'h5A;

   localparam int HEARTBEAT_BITS = 25;
   localparam int FLASH_BIT      = 22;   // Fast flash rate on error

   // ADDR_STATUS bits
   localparam int STAT_FIFO_ERR = 0;
   localparam int STAT_XADC_ERR = 1;

   // ADDR_TARGET_CTRL bits
   localparam int TCTL_POWER_OFF = 0;
   localparam int TCTL_AVRPROG   = 1;
   localparam int TCTL_NRST_OE   = 2;
   localparam int TCTL_NRST_VAL  = 3;
   localparam int TCTL_PDID_OE   = 4;
   localparam int TCTL_PDID_VAL  = 5;
   localparam int TCTL_PDIC_OE   = 6;
   localparam int TCTL_PDIC_VAL  = 7;

   // ADDR_TRIG_MODE bits
   localparam int TRIG_MODE_AND = 0;

endpackage

//--- rtl/usb_reg_bridge.sv
`timescale 1ns/1ps

module usb_reg_bridge
   import husky_pkg::*;
(
   input  logic       clk_usb_buf,
   input  logic       rst_i,
   input  reg_addr_t  usb_addr_i,
   input  reg_data_t  usb_data_i,
   input  logic       usb_alen_i,
   input  logic       usb_cen_i,
   input  logic       usb_rdn_i,
   input  logic       usb_wrn_i,
   input  reg_data_t  rdata_i,
   output reg_data_t  usb_data_o,
   output logic       usb_data_oe_o,
   output reg_bus_t   bus_o
);

   bus_state_e state;
   reg_addr_t  addr_q;
   reg_data_t  wdata_q;
   reg_data_t  hold_q;
   logic       rd_q;
   logic       wr_q;
   logic       start_wr;
   logic       start_rd;

   // Only the first sampled low edge of a strobe starts a cycle
   assign start_wr = (state == BUS_IDLE) && !usb_cen_i && !usb_wrn_i;
   assign start_rd = (state == BUS_IDLE) && !usb_cen_i && !usb_rdn_i && usb_wrn_i;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state <= BUS_IDLE;
         rd_q  <= 1'b0;
         wr_q  <= 1'b0;
      end else begin
         rd_q <= 1'b0;
         wr_q <= 1'b0;
         case (state)
            BUS_IDLE: begin
               if (start_wr) begin
                  state <= BUS_WRITE;
                  wr_q  <= 1'b1;
               end else if (start_rd) begin
                  state <= BUS_READ;
                  rd_q  <= 1'b1;
               end
            end
            BUS_WRITE: if (usb_wrn_i) state <= BUS_IDLE;   // Wait for wrn to rise
            BUS_READ:  if (usb_rdn_i) state <= BUS_IDLE;
            default:   state <= BUS_IDLE;
         endcase
      end
   end

   // Address latch, open while ALE and CE are both low
   always_ff @(posedge clk_usb_buf) begin
      if (!usb_alen_i && !usb_cen_i) addr_q <= usb_addr_i;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (start_wr) wdata_q <= usb_data_i;
   end

   // Merged peer data is valid during the read strobe
   always_ff @(posedge clk_usb_buf) begin
      if (rd_q) hold_q <= rdata_i;
   end

   assign bus_o = '{addr: addr_q, wdata: wdata_q, rd: rd_q, wr: wr_q};

   assign usb_data_o    = hold_q;
   assign usb_data_oe_o = (state == BUS_READ) && !rd_q && !usb_rdn_i;

   // Strobes are exclusive single-cycle pulses
   a_strobe_excl: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      !(rd_q && wr_q));
   a_rd_pulse: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      rd_q |=> !rd_q);
   a_wr_pulse: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      wr_q |=> !wr_q);

endmodule

//--- rtl/reg_status_led.sv
`timescale 1ns/1ps

module reg_status_led
   import husky_pkg::*;
(
   input  logic       clk_usb_buf,
   input  logic       rst_i,
   input  reg_bus_t   bus_i,
   input  logic       fifo_error_i,
   input  logic       xadc_error_i,
   input  logic       pll_status_i,
   input  logic       glitch_led_i,
   output reg_data_t  rdata_o,
   output logic       led_adc_o,
   output logic       led_glitch_o
);

   logic [HEARTBEAT_BITS-1:0] heartbeat_q;
   logic [1:0]                flags_q;
   logic [1:0]                flag_set;
   logic [1:0]                flag_clr;
   logic                      error_any;

   assign flag_set[STAT_FIFO_ERR] = fifo_error_i;
   assign flag_set[STAT_XADC_ERR] = xadc_error_i;

   // Write one to clear
   assign flag_clr = (bus_i.wr && bus_i.addr == ADDR_STATUS) ? bus_i.wdata[1:0] : 2'b00;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         flags_q     <= '0;
         heartbeat_q <= '0;
      end else begin
         flags_q     <= (flags_q & ~flag_clr) | flag_set;   // Set beats clear
         heartbeat_q <= heartbeat_q + 1'b1;
      end
   end

   always_comb begin
      rdata_o = '0;
      if (bus_i.rd) begin
         case (bus_i.addr)
            ADDR_ID:     rdata_o = BOARD_ID;
            ADDR_STATUS: rdata_o = reg_data_t'(flags_q);
            default:     rdata_o = '0;
         endcase
      end
   end

   assign error_any = |flags_q;

   // Both red LEDs flash together while an error is latched
   assign led_adc_o    = error_any ? heartbeat_q[FLASH_BIT] : ~pll_status_i;
   assign led_glitch_o = error_any ? heartbeat_q[FLASH_BIT] : glitch_led_i;

endmodule

//--- rtl/reg_target_io.sv
`timescale 1ns/1ps

module reg_target_io
   import husky_pkg::*;
(
   input  logic          clk_usb_buf,
   input  logic          rst_i,
   input  reg_bus_t      bus_i,
   input  logic          sam_mosi_i,
   input  logic          sam_spck_i,
   input  logic          target_miso_i,
   output reg_data_t     rdata_o,
   output target_pins_t  pins_o,
   output logic          target_poweron_o
);

   reg_data_t ctrl_q;    // Host-visible control byte
   reg_data_t drive_q;   // Copy that the pin logic works from
   logic      power_off;
   logic      avrprog;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         ctrl_q  <= '0;
         drive_q <= '0;
      end else begin
         if (bus_i.wr && bus_i.addr == ADDR_TARGET_CTRL) ctrl_q <= bus_i.wdata;
         drive_q <= ctrl_q;   // Pin stage, one cycle behind the register
      end
   end

   assign rdata_o = (bus_i.rd && bus_i.addr == ADDR_TARGET_CTRL) ? ctrl_q : '0;

   assign power_off        = drive_q[TCTL_POWER_OFF];
   assign avrprog          = drive_q[TCTL_AVRPROG];
   assign target_poweron_o = ~power_off;

   always_comb begin
      pins_o = '0;

      // MISO back to the SAM is on the board side, so power does not matter
      if (avrprog) begin
         pins_o.sam_miso = '{val: target_miso_i, oe: 1'b1};
      end

      if (!power_off) begin
         if (avrprog) begin
            pins_o.nrst = '{val: 1'b0, oe: 1'b1};   // Hold target in reset
            pins_o.mosi = '{val: sam_mosi_i, oe: 1'b1};
            pins_o.sck  = '{val: sam_spck_i, oe: 1'b1};
         end else begin
            if (drive_q[TCTL_NRST_OE]) begin
               pins_o.nrst = '{val: drive_q[TCTL_NRST_VAL], oe: 1'b1};
            end
            if (drive_q[TCTL_PDID_OE]) begin
               pins_o.pdid = '{val: drive_q[TCTL_PDID_VAL], oe: 1'b1};
            end
            if (drive_q[TCTL_PDIC_OE]) begin
               pins_o.pdic = '{val: drive_q[TCTL_PDIC_VAL], oe: 1'b1};
            end
         end
      end
   end

   // A power-off write floats every target pin once it reaches the pin stage
   a_power_off_float: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      ctrl_q[TCTL_POWER_OFF] |=> !(pins_o.nrst.oe || pins_o.pdid.oe || pins_o.pdic.oe
                                   || pins_o.mosi.oe || pins_o.sck.oe));

endmodule

//--- rtl/reg_trigger_select.sv
`timescale 1ns/1ps

module reg_trigger_select
   import husky_pkg::*;
(
   input  logic       clk_usb_buf,
   input  logic       rst_i,
   input  reg_bus_t   bus_i,
   input  trig_src_t  trig_in_i,
   output reg_data_t  rdata_o,
   output logic       trigger_o
);

   trig_src_t mask_q;
   logic      mode_and_q;
   logic      or_hit;
   logic      and_hit;
   logic      trigger_q;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         mask_q     <= '0;
         mode_and_q <= 1'b0;
      end else if (bus_i.wr) begin
         if (bus_i.addr == ADDR_TRIG_SRC) mask_q <= bus_i.wdata[4:0];
         if (bus_i.addr == ADDR_TRIG_MODE) mode_and_q <= bus_i.wdata[TRIG_MODE_AND];
      end
   end

   always_comb begin
      rdata_o = '0;
      if (bus_i.rd) begin
         case (bus_i.addr)
            ADDR_TRIG_SRC:  rdata_o = reg_data_t'(mask_q);
            ADDR_TRIG_MODE: rdata_o = reg_data_t'(mode_and_q);
            default:        rdata_o = '0;
         endcase
      end
   end

   assign or_hit = |(trig_in_i & mask_q);

   // Unmasked inputs count as high, an empty mask never fires
   assign and_hit = (mask_q != '0) && (&(trig_in_i | ~mask_q));

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         trigger_q <= 1'b0;
      end else begin
         trigger_q <= mode_and_q ? and_hit : or_hit;
      end
   end

   assign trigger_o = trigger_q;

   a_no_mask_no_trig: assert property (@(posedge clk_usb_buf) disable iff (rst_i)
      (mask_q == '0) |=> !trigger_o);

endmodule

//--- rtl/husky_top.sv
`timescale 1ns/1ps

module husky_top
   import husky_pkg::*;
(
   input  logic          clk_usb_buf,
   input  logic          rst_i,

   // USB register bus from the microcontroller
   input  reg_addr_t     usb_addr_i,
   input  reg_data_t     usb_data_i,
   input  logic          usb_alen_i,
   input  logic          usb_cen_i,
   input  logic          usb_rdn_i,
   input  logic          usb_wrn_i,
   output reg_data_t     usb_data_o,
   output logic          usb_data_oe_o,

   // Status and LEDs
   input  logic          fifo_error_i,
   input  logic          xadc_error_i,
   input  logic          pll_status_i,
   input  logic          glitch_led_i,
   output logic          led_adc_o,
   output logic          led_glitch_o,

   // Target I/O
   input  logic          sam_mosi_i,
   input  logic          sam_spck_i,
   input  logic          target_miso_i,
   output target_pins_t  pins_o,
   output logic          target_poweron_o,

   // Trigger
   input  trig_src_t     trig_in_i,
   output logic          trigger_o
);

   reg_bus_t  reg_bus;
   reg_data_t rdata_status;
   reg_data_t rdata_target;
   reg_data_t rdata_trig;
   reg_data_t rdata_merged;

   // Unaddressed peers return zero
   assign rdata_merged = rdata_status | rdata_target | rdata_trig;

   usb_reg_bridge i_usb_reg_bridge (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_alen_i    (usb_alen_i),
      .usb_cen_i     (usb_cen_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .rdata_i       (rdata_merged),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .bus_o         (reg_bus)
   );

   reg_status_led i_reg_status_led (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .bus_i        (reg_bus),
      .fifo_error_i (fifo_error_i),
      .xadc_error_i (xadc_error_i),
      .pll_status_i (pll_status_i),
      .glitch_led_i (glitch_led_i),
      .rdata_o      (rdata_status),
      .led_adc_o    (led_adc_o),
      .led_glitch_o (led_glitch_o)
   );

   reg_target_io i_reg_target_io (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .bus_i            (reg_bus),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .rdata_o          (rdata_target),
      .pins_o           (pins_o),
      .target_poweron_o (target_poweron_o)
   );

   reg_trigger_select i_reg_trigger_select (
      .clk_usb_buf (clk_usb_buf),
      .rst_i       (rst_i),
      .bus_i       (reg_bus),
      .trig_in_i   (trig_in_i),
      .rdata_o     (rdata_trig),
      .trigger_o   (trigger_o)
   );

endmodule

//--- testbench/tb_husky_bus.svh
`ifndef TB_HUSKY_BUS_SVH
`define TB_HUSKY_BUS_SVH

// Compare one observed value with its expected value
task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
   checks_run++;
   assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
   end
endtask

task automatic check_pins(input target_pins_t exp_pins, input logic exp_power);
   check_value("pins_o", pins, exp_pins);
   check_value("target_poweron_o", target_poweron, exp_power);
endtask

// Called on a falling edge, returns on a falling edge
task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
   usb_addr = addr;
   usb_alen = 1'b0;                        // Address phase
   usb_cen  = 1'b0;
   @(negedge clk_usb_buf);
   usb_alen    = 1'b1;
   usb_data_in = data;
   usb_wrn     = 1'b0;
   repeat (3) @(negedge clk_usb_buf);      // Strobe, register, pin stage
   usb_wrn = 1'b1;
   usb_cen = 1'b1;
   @(negedge clk_usb_buf);
endtask

// Read data is sampled on the last of four cycles with rdn low
task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
   usb_addr = addr;
   usb_alen = 1'b0;
   usb_cen  = 1'b0;
   @(negedge clk_usb_buf);
   usb_alen = 1'b1;
   usb_rdn  = 1'b0;
   repeat (4) @(negedge clk_usb_buf);
   check_value("usb_data_oe_o", usb_data_oe, 1'b1);
   data    = usb_data_out;
   usb_rdn = 1'b1;
   usb_cen = 1'b1;
   @(negedge clk_usb_buf);
   check_value("usb_data_oe_o", usb_data_oe, 1'b0);   // Released with rdn
endtask

`endif

//--- testbench/tb_husky_top.sv
`timescale 1ns/1ps

module tb_husky_top
   import husky_pkg::*;
();

   localparam int CLK_HALF    = 20;   // 40 ns period
   localparam int STEP_CYCLES = 12;

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_PULSE,
      OP_IDLE
   } op_e;

   typedef struct packed {
      op_e          op;
      reg_addr_t    addr;
      reg_data_t    data;
      logic [2:0]   sam;           // mosi, spck, target miso from bit 2 down
      trig_src_t    trig;
      logic         pll;
      logic         glitch;
      reg_data_t    exp_rd;
      target_pins_t exp_pins;
      logic         exp_poweron;
      logic         exp_trig;
      logic         chk_led;
   } step_t;

   logic         clk_usb_buf;
   logic         rst;
   reg_addr_t    usb_addr;
   reg_data_t    usb_data_in;
   reg_data_t    usb_data_out;
   logic         usb_alen;
   logic         usb_cen;
   logic         usb_rdn;
   logic         usb_wrn;
   logic         usb_data_oe;
   logic         fifo_error;
   logic         xadc_error;
   logic         pll_status;
   logic         glitch_led;
   logic         led_adc;
   logic         led_glitch;
   logic         sam_mosi;
   logic         sam_spck;
   logic         target_miso;
   target_pins_t pins;
   logic         target_poweron;
   trig_src_t    trig_in;
   logic         trigger;

   step_t      steps[$];
   bit         table_built;
   int         checks_run;
   int         errors;
   reg_data_t  model_ctrl;      // Register state as the table expects it
   trig_src_t  model_mask;
   logic       model_and;
   logic [1:0] model_flags;

   `include "tb_husky_bus.svh"

   husky_top i_husky_top (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst),
      .usb_addr_i       (usb_addr),
      .usb_data_i       (usb_data_in),
      .usb_alen_i       (usb_alen),
      .usb_cen_i        (usb_cen),
      .usb_rdn_i        (usb_rdn),
      .usb_wrn_i        (usb_wrn),
      .usb_data_o       (usb_data_out),
      .usb_data_oe_o    (usb_data_oe),
      .fifo_error_i     (fifo_error),
      .xadc_error_i     (xadc_error),
      .pll_status_i     (pll_status),
      .glitch_led_i     (glitch_led),
      .led_adc_o        (led_adc),
      .led_glitch_o     (led_glitch),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .target_miso_i    (target_miso),
      .pins_o           (pins),
      .target_poweron_o (target_poweron),
      .trig_in_i        (trig_in),
      .trigger_o        (trigger)
   );

   initial clk_usb_buf = 1'b0;
   always #CLK_HALF clk_usb_buf = ~clk_usb_buf;

   // Priority is power off, then AVR programming, then the OE and VAL bits
   function automatic target_pins_t expected_pins(input reg_data_t ctrl, input logic [2:0] sam);
      target_pins_t p;
      logic         powered;
      logic         avr;
      powered = !ctrl[TCTL_POWER_OFF];
      avr     = ctrl[TCTL_AVRPROG];
      p       = '0;
      if (avr) p.sam_miso = {sam[0], 1'b1};   // Board side, power ignored
      if (powered && avr) begin
         p.nrst = {1'b0, 1'b1};
         p.mosi = {sam[2], 1'b1};
         p.sck  = {sam[1], 1'b1};
      end
      if (powered && !avr) begin
         if (ctrl[TCTL_NRST_OE]) p.nrst = {ctrl[TCTL_NRST_VAL], 1'b1};
         if (ctrl[TCTL_PDID_OE]) p.pdid = {ctrl[TCTL_PDID_VAL], 1'b1};
         if (ctrl[TCTL_PDIC_OE]) p.pdic = {ctrl[TCTL_PDIC_VAL], 1'b1};
      end
      return p;
   endfunction

   function automatic logic expected_trigger(input trig_src_t mask, input logic mode_and,
                                             input trig_src_t in);
      if (mask == '0) return 1'b0;
      if (mode_and) return (in & mask) == mask;
      return (in & mask) != '0;
   endfunction

   function automatic reg_data_t expected_read(input reg_addr_t addr);
      case (addr)
         ADDR_ID:          return BOARD_ID;
         ADDR_STATUS:      return {6'b0, model_flags};
         ADDR_TARGET_CTRL: return model_ctrl;
         ADDR_TRIG_SRC:    return {3'b0, model_mask};
         ADDR_TRIG_MODE:   return {7'b0, model_and};
         default:          return 8'h00;
      endcase
   endfunction

   // Random inputs per step, expectations from the register state after it
   task automatic add_step(input op_e op, input reg_addr_t addr, input reg_data_t data);
      step_t s;
      s        = '0;
      s.op     = op;
      s.addr   = addr;
      s.data   = data;
      s.sam    = 3'($urandom);
      s.trig   = trig_src_t'($urandom);
      s.pll    = 1'($urandom);
      s.glitch = 1'($urandom);
      if ($urandom % 2 == 1) s.trig = s.trig | model_mask;   // Gives AND mode some hits
      if (op == OP_WRITE) begin
         case (addr)
            ADDR_STATUS:      model_flags = model_flags & ~data[1:0];
            ADDR_TARGET_CTRL: model_ctrl = data;
            ADDR_TRIG_SRC:    model_mask = data[4:0];
            ADDR_TRIG_MODE:   model_and = data[0];
            default:          ;
         endcase
      end
      if (op == OP_PULSE) model_flags = model_flags | data[1:0];
      s.exp_rd      = expected_read(addr);
      s.exp_pins    = expected_pins(model_ctrl, s.sam);
      s.exp_poweron = !model_ctrl[TCTL_POWER_OFF];
      s.exp_trig    = expected_trigger(model_mask, model_and, s.trig);
      s.chk_led     = (model_flags == 2'b00);
      steps.push_back(s);
   endtask

   task automatic build_steps();
      model_ctrl  = '0;
      model_mask  = '0;
      model_and   = 1'b0;
      model_flags = '0;
      add_step(OP_READ, ADDR_ID, 8'h00);
      add_step(OP_WRITE, ADDR_ID, 8'hC3);           // Read-only
      add_step(OP_READ, ADDR_ID, 8'h00);
      add_step(OP_WRITE, ADDR_TARGET_CTRL, 8'h6C);
      add_step(OP_READ, ADDR_TARGET_CTRL, 8'h00);
      add_step(OP_WRITE, ADDR_TRIG_SRC, 8'hEB);
      add_step(OP_READ, ADDR_TRIG_SRC, 8'h00);
      add_step(OP_WRITE, ADDR_TRIG_MODE, 8'hFF);
      add_step(OP_READ, ADDR_TRIG_MODE, 8'h00);
      add_step(OP_READ, 8'h7E, 8'h00);              // Unmapped
      add_step(OP_WRITE, ADDR_TARGET_CTRL, 8'h02);  // AVR programming, powered
      add_step(OP_WRITE, ADDR_TARGET_CTRL, 8'h03);  // AVR programming, power off
      add_step(OP_WRITE, ADDR_TARGET_CTRL, 8'hFC);
      repeat (8) add_step(OP_WRITE, ADDR_TARGET_CTRL, reg_data_t'($urandom));
      for (int mode = 0; mode < 2; mode++) begin
         add_step(OP_WRITE, ADDR_TRIG_MODE, reg_data_t'(mode));
         repeat (3) begin
            add_step(OP_WRITE, ADDR_TRIG_SRC, reg_data_t'($urandom));
            repeat (3) add_step(OP_IDLE, 8'h00, 8'h00);
         end
         add_step(OP_WRITE, ADDR_TRIG_SRC, 8'h00);
         repeat (2) add_step(OP_IDLE, 8'h00, 8'h00);
      end
      add_step(OP_PULSE, 8'h00, 8'h01);
      add_step(OP_READ, ADDR_STATUS, 8'h00);
      add_step(OP_WRITE, ADDR_STATUS, 8'h01);
      add_step(OP_READ, ADDR_STATUS, 8'h00);
      add_step(OP_PULSE, 8'h00, 8'h02);
      add_step(OP_READ, ADDR_STATUS, 8'h00);
      add_step(OP_WRITE, ADDR_STATUS, 8'h03);
      add_step(OP_READ, ADDR_STATUS, 8'h00);
      repeat (4) add_step(OP_IDLE, 8'h00, 8'h00);
   endtask

   task automatic run_step(input step_t s);
      reg_data_t rd;
      sam_mosi    = s.sam[2];
      sam_spck    = s.sam[1];
      target_miso = s.sam[0];
      trig_in     = s.trig;
      pll_status  = s.pll;
      glitch_led  = s.glitch;
      case (s.op)
         OP_WRITE: bus_write(s.addr, s.data);
         OP_READ: begin
            bus_read(s.addr, rd);
            check_value("usb_data_o", rd, s.exp_rd);
         end
         OP_PULSE: begin
            fifo_error = s.data[STAT_FIFO_ERR];
            xadc_error = s.data[STAT_XADC_ERR];
            @(negedge clk_usb_buf);
            fifo_error = 1'b0;
            xadc_error = 1'b0;
            @(negedge clk_usb_buf);
         end
         default: @(negedge clk_usb_buf);
      endcase
      check_pins(s.exp_pins, s.exp_poweron);
      check_value("trigger_o", trigger, s.exp_trig);
      if (s.chk_led) begin
         check_value("led_adc_o", led_adc, !s.pll);
         check_value("led_glitch_o", led_glitch, s.glitch);
      end
   endtask

   initial begin
      void'($urandom(64));
      rst         = 1'b1;
      usb_addr    = '0;
      usb_data_in = '0;
      usb_alen    = 1'b1;
      usb_cen     = 1'b1;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      fifo_error  = 1'b0;
      xadc_error  = 1'b0;
      pll_status  = 1'b1;
      glitch_led  = 1'b0;
      sam_mosi    = 1'b0;
      sam_spck    = 1'b0;
      target_miso = 1'b0;
      trig_in     = '0;
      checks_run  = 0;
      errors      = 0;
      build_steps();
      table_built = 1'b1;
      repeat (3) @(negedge clk_usb_buf);
      rst = 1'b0;
      @(negedge clk_usb_buf);
      check_value("usb_data_oe_o", usb_data_oe, 1'b0);
      check_pins('0, 1'b1);
      check_value("trigger_o", trigger, 1'b0);
      foreach (steps[i]) run_step(steps[i]);
      $display("Checks run: %0d, errors: %0d", checks_run, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Twice the worst-case length of the whole table
   initial begin
      wait (table_built);
      repeat (steps.size() * STEP_CYCLES * 2) @(posedge clk_usb_buf);
      $display("Watchdog timeout: the stimulus table did not finish in time");
      $display("Checks run: %0d, errors: %0d", checks_run, errors + 1);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- all.f
+incdir+testbench
rtl/husky_pkg.sv
rtl/usb_reg_bridge.sv
rtl/reg_status_led.sv
rtl/reg_target_io.sv
rtl/reg_trigger_select.sv
rtl/husky_top.sv
testbench/tb_husky_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the husky_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_husky_top -Mdir "$OBJ_DIR" -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ_DIR/Vtb_husky_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   echo "Simulation FAILED, see $LOG"
   exit 1
fi

echo "Simulation passed"
exit 0
